// ==== project.f ====
+incdir+src
src/issue_pkg.sv
src/inst_predecode.sv
src/dual_slot_fifo.sv
src/issue_picker.sv
src/issue_stage.sv
testbench/issue_stage_checker.sv
testbench/issue_stage_tb.sv

// ==== src/dual_slot_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "issue_defs.svh"

module dual_slot_fifo #(
    parameter type T = issue_pkg::decoded_inst_t
) (
    input  wire logic       clk,
    input  wire logic       rstn,
    input  wire logic       i_flush,

    input  wire T           i_data1,
    input  wire T           i_data2,
    input  wire logic [1:0] i_push_count,  // 0, 1 or 2 new entries
    input  wire logic [1:0] i_pop_count,   // entries leaving at the head

    output T                o_head1,
    output T                o_head2,
    output logic [1:0]      o_head_valid,  // 00 empty, 10 one, 11 two or more
    output logic            o_full
);

    localparam int DEPTH = `ISSUE_DEPTH;
    localparam int PTR_W = `ISSUE_PTR_W;
    localparam int OCC_W = PTR_W + 1;  // occupancy reaches DEPTH itself

    localparam logic [OCC_W-1:0] FULL_LEVEL = OCC_W'(DEPTH - `ISSUE_FULL_MARGIN);

    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr_plus1;
    logic [PTR_W-1:0] rd_ptr_plus1;
    logic [PTR_W-1:0] wr_ptr_next;
    logic [PTR_W-1:0] rd_ptr_next;

    logic [OCC_W-1:0] occ;
    logic [OCC_W-1:0] occ_after_pop;
    logic [OCC_W-1:0] occ_next;
    logic [1:0]       head_valid_next;

    //////////////////////////////////////////////////////////////////////
    // pointer and occupancy arithmetic
    //////////////////////////////////////////////////////////////////////

    // depth is a power of two, so pointers wrap on their own
    assign wr_ptr_plus1 = wr_ptr + PTR_W'(1);
    assign rd_ptr_plus1 = rd_ptr + PTR_W'(1);
    assign wr_ptr_next  = wr_ptr + PTR_W'(i_push_count);
    assign rd_ptr_next  = rd_ptr + PTR_W'(i_pop_count);

    // pop count comes from the picker and never exceeds the head code
    assign occ_after_pop = occ - OCC_W'(i_pop_count);
    assign occ_next      = occ_after_pop + OCC_W'(i_push_count);

    always_comb begin
        case (occ_next)
            OCC_W'(0): head_valid_next = 2'b00;
            OCC_W'(1): head_valid_next = 2'b10;
            default:   head_valid_next = 2'b11;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!i_flush) begin  // pushes in a flush cycle are dropped
            if (i_push_count != 2'd0) begin
                mem[wr_ptr] <= i_data1;
            end
            if (i_push_count == 2'd2) begin
                mem[wr_ptr_plus1] <= i_data2;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // control state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn || i_flush) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            occ          <= '0;
            o_head_valid <= 2'b00;
            o_full       <= 1'b0;
        end else begin
            wr_ptr       <= wr_ptr_next;
            rd_ptr       <= rd_ptr_next;
            occ          <= occ_next;
            o_head_valid <= head_valid_next;
            // margin check ignores this cycle's pushes, as fetch already has them in flight
            o_full       <= (occ_after_pop >= FULL_LEVEL);
        end
    end

    // two oldest entries straight from the array
    assign o_head1 = mem[rd_ptr];
    assign o_head2 = mem[rd_ptr_plus1];

endmodule

`default_nettype wire

// ==== src/inst_predecode.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "issue_defs.svh"

module inst_predecode (
    input  wire logic                    i_valid,
    input  wire logic [31:0]             i_instr,
    input  wire logic [31:0]             i_pc,
    output issue_pkg::decoded_inst_t     o_inst
);

    logic [5:0]  opcode;
    logic [4:0]  f_rd;
    logic [4:0]  f_rj;
    logic [4:0]  f_rk;
    logic [13:0] f_csr;

    // raw instruction fields
    assign opcode = i_instr[31:26];
    assign f_rd   = i_instr[4:0];
    assign f_rj   = i_instr[9:5];
    assign f_rk   = i_instr[14:10];
    assign f_csr  = i_instr[23:10];

    always_comb begin
        o_inst           = '0;
        o_inst.valid     = i_valid;
        o_inst.pc        = i_pc;
        o_inst.instr     = i_instr;
        o_inst.rd        = f_rd;
        o_inst.imm       = i_instr[21:10];  // overlaps rk, only meaningful for I forms
        o_inst.kind      = issue_pkg::KIND_ILLEGAL;

        case (opcode)
            `OPC_ALU_R: begin
                o_inst.kind      = issue_pkg::KIND_ALU;
                o_inst.rf_raddr1 = f_rj;
                o_inst.rf_raddr2 = f_rk;
                o_inst.uses_r2   = 1'b1;
                o_inst.rf_we     = 1'b1;
            end
            `OPC_ALU_I: begin
                o_inst.kind      = issue_pkg::KIND_ALU;
                o_inst.rf_raddr1 = f_rj;
                o_inst.rf_we     = 1'b1;
            end
            `OPC_LOAD: begin
                o_inst.kind      = issue_pkg::KIND_LOAD;
                o_inst.rf_raddr1 = f_rj;  // base
                o_inst.rf_we     = 1'b1;
            end
            `OPC_STORE: begin
                o_inst.kind      = issue_pkg::KIND_STORE;
                o_inst.rf_raddr1 = f_rj;  // base
                o_inst.rf_raddr2 = f_rd;  // store data
                o_inst.uses_r2   = 1'b1;
            end
            `OPC_BRANCH: begin
                o_inst.kind      = issue_pkg::KIND_BRANCH;
                o_inst.rf_raddr1 = f_rj;
                o_inst.rf_raddr2 = f_rd;
                o_inst.uses_r2   = 1'b1;
            end
            `OPC_CSR: begin
                // csr exchange: old value to rd, rd written back to csr
                o_inst.kind      = issue_pkg::KIND_CSR;
                o_inst.rf_raddr1 = f_rd;
                o_inst.rf_we     = 1'b1;
                o_inst.csr_addr  = f_csr;
            end
            default: begin
                // unknown opcode, no register use at all
                o_inst.kind      = issue_pkg::KIND_ILLEGAL;
            end
        endcase

        // r0 is hardwired, a write to it is no write
        if (f_rd == 5'd0) begin
            o_inst.rf_we = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/issue_defs.svh ====
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// issue buffer geometry
//////////////////////////////////////////////////////////////////////
`define ISSUE_DEPTH        16
`define ISSUE_PTR_W        4   // log2 of depth
`define ISSUE_FULL_MARGIN  8   // free entries kept for the fetch path

//////////////////////////////////////////////////////////////////////
// opcode values, instr[31:26]
//////////////////////////////////////////////////////////////////////
`define OPC_ALU_R   6'h01  // rd = rj op rk
`define OPC_ALU_I   6'h02  // rd = rj op imm
`define OPC_LOAD    6'h03
`define OPC_STORE   6'h04  // mem[rj + imm] = rd
`define OPC_BRANCH  6'h05  // compare rj with rd
`define OPC_CSR     6'h06

`endif

// ==== src/issue_picker.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_picker (
    input  wire issue_pkg::decoded_inst_t i_head1,
    input  wire issue_pkg::decoded_inst_t i_head2,
    input  wire logic [1:0]               i_head_valid,

    input  wire logic                     i_stall_mem,
    input  wire logic                     i_stall_ex,
    input  wire logic                     i_flush,

    output logic [1:0]                    o_pop_count,
    output issue_pkg::decoded_inst_t      o_issue1,
    output issue_pkg::decoded_inst_t      o_issue2,

    output logic [4:0]                    o_a_raddr1,
    output logic [4:0]                    o_a_raddr2,
    output logic [4:0]                    o_b_raddr1,
    output logic [4:0]                    o_b_raddr2,
    output logic [13:0]                   o_csr_raddr1,
    output logic [13:0]                   o_csr_raddr2
);

    logic stall;
    logic raw_hazard;
    logic mem_pair;
    logic serialize;
    logic dual_ok;
    logic issue_a;
    logic issue_b;

    assign stall = i_stall_mem | i_stall_ex;

    //////////////////////////////////////////////////////////////////////
    // pairing hazards between head 1 and head 2
    //////////////////////////////////////////////////////////////////////

    // head 2 reads what head 1 is about to write
    assign raw_hazard = i_head1.rf_we && (i_head1.rd != 5'd0) &&
                        ((i_head2.rf_raddr1 == i_head1.rd) ||
                         (i_head2.uses_r2 && (i_head2.rf_raddr2 == i_head1.rd)));

    // only one memory port downstream
    assign mem_pair = ((i_head1.kind == issue_pkg::KIND_LOAD) ||
                       (i_head1.kind == issue_pkg::KIND_STORE)) &&
                      ((i_head2.kind == issue_pkg::KIND_LOAD) ||
                       (i_head2.kind == issue_pkg::KIND_STORE));

    // csr and branch always go alone
    assign serialize = (i_head1.kind == issue_pkg::KIND_CSR) ||
                       (i_head1.kind == issue_pkg::KIND_BRANCH) ||
                       (i_head2.kind == issue_pkg::KIND_CSR) ||
                       (i_head2.kind == issue_pkg::KIND_BRANCH);

    assign dual_ok = i_head_valid[0] && !raw_hazard && !mem_pair && !serialize;

    always_comb begin
        if (i_flush || stall || !i_head_valid[1]) begin
            o_pop_count = 2'd0;
        end else if (dual_ok) begin
            o_pop_count = 2'd2;
        end else begin
            o_pop_count = 2'd1;
        end
    end

    assign issue_a = (o_pop_count != 2'd0);
    assign issue_b = (o_pop_count == 2'd2);

    //////////////////////////////////////////////////////////////////////
    // issue records and read addresses
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        o_issue1       = i_head1;
        o_issue1.valid = issue_a;
        o_issue2       = issue_b ? i_head2 : '0;  // idle slot b is all zero
        o_issue2.valid = issue_b;
    end

    // slot a reads ahead even when it does not issue
    assign o_a_raddr1   = i_head1.rf_raddr1;
    assign o_a_raddr2   = i_head1.rf_raddr2;
    assign o_csr_raddr1 = i_head1.csr_addr;

    assign o_b_raddr1   = issue_b ? i_head2.rf_raddr1 : 5'd0;
    assign o_b_raddr2   = issue_b ? i_head2.rf_raddr2 : 5'd0;
    assign o_csr_raddr2 = issue_b ? i_head2.csr_addr  : 14'd0;

endmodule

`default_nettype wire

// ==== src/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

    // coarse class of a decoded instruction, used by the issue rule
    typedef enum logic [2:0] {
        KIND_ALU     = 3'd0,
        KIND_LOAD    = 3'd1,
        KIND_STORE   = 3'd2,
        KIND_BRANCH  = 3'd3,
        KIND_CSR     = 3'd4,
        KIND_ILLEGAL = 3'd5
    } inst_kind_e;

    // one predecoded instruction as it sits in the issue buffer
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        inst_kind_e  kind;
        logic [4:0]  rd;
        logic        rf_we;       // never set for rd 0
        logic [4:0]  rf_raddr1;
        logic [4:0]  rf_raddr2;
        logic        uses_r2;     // second read port really used
        logic [13:0] csr_addr;
        logic [11:0] imm;
    } decoded_inst_t;

endpackage

`default_nettype wire

// ==== src/issue_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_stage (
    input  wire logic                clk,
    input  wire logic                rstn,

    // fetch slots, slot 2 only together with slot 1
    input  wire logic                i_valid1,
    input  wire logic [31:0]         i_instr1,
    input  wire logic [31:0]         i_pc1,
    input  wire logic                i_valid2,
    input  wire logic [31:0]         i_instr2,
    input  wire logic [31:0]         i_pc2,

    input  wire logic                i_flush,
    input  wire logic                i_stall_mem,
    input  wire logic                i_stall_ex,

    output logic [1:0]               o_issue_count,
    output issue_pkg::decoded_inst_t o_issue1,
    output issue_pkg::decoded_inst_t o_issue2,

    output logic [4:0]               o_a_raddr1,
    output logic [4:0]               o_a_raddr2,
    output logic [4:0]               o_b_raddr1,
    output logic [4:0]               o_b_raddr2,
    output logic [13:0]              o_csr_raddr1,
    output logic [13:0]              o_csr_raddr2,

    output logic                     o_full
);

    issue_pkg::decoded_inst_t inst1;
    issue_pkg::decoded_inst_t inst2;
    issue_pkg::decoded_inst_t head1;
    issue_pkg::decoded_inst_t head2;
    logic [1:0]               head_valid;
    logic [1:0]               push_count;
    logic [1:0]               pop_count;

    inst_predecode u_predecode1 (
        .i_valid (i_valid1),
        .i_instr (i_instr1),
        .i_pc    (i_pc1),
        .o_inst  (inst1)
    );

    inst_predecode u_predecode2 (
        .i_valid (i_valid2),
        .i_instr (i_instr2),
        .i_pc    (i_pc2),
        .o_inst  (inst2)
    );

    // buffer sees a count, not the record valid bits
    assign push_count = i_valid1 ? (i_valid2 ? 2'd2 : 2'd1) : 2'd0;

    dual_slot_fifo #(
        .T (issue_pkg::decoded_inst_t)
    ) u_fifo (
        .clk          (clk),
        .rstn         (rstn),
        .i_flush      (i_flush),
        .i_data1      (inst1),
        .i_data2      (inst2),
        .i_push_count (push_count),
        .i_pop_count  (pop_count),
        .o_head1      (head1),
        .o_head2      (head2),
        .o_head_valid (head_valid),
        .o_full       (o_full)
    );

    issue_picker u_picker (
        .i_head1      (head1),
        .i_head2      (head2),
        .i_head_valid (head_valid),
        .i_stall_mem  (i_stall_mem),
        .i_stall_ex   (i_stall_ex),
        .i_flush      (i_flush),
        .o_pop_count  (pop_count),
        .o_issue1     (o_issue1),
        .o_issue2     (o_issue2),
        .o_a_raddr1   (o_a_raddr1),
        .o_a_raddr2   (o_a_raddr2),
        .o_b_raddr1   (o_b_raddr1),
        .o_b_raddr2   (o_b_raddr2),
        .o_csr_raddr1 (o_csr_raddr1),
        .o_csr_raddr2 (o_csr_raddr2)
    );

    assign o_issue_count = pop_count;  // what leaves the buffer is what issues

endmodule

`default_nettype wire

// ==== testbench/issue_stage_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_stage_checker (
    input  wire logic                     clk,
    input  wire logic                     rstn,
    input  wire logic                     i_valid1,
    input  wire logic                     i_valid2,
    input  wire logic                     i_stall_mem,
    input  wire logic                     i_stall_ex,
    input  wire logic                     o_full,
    input  wire logic [1:0]               o_issue_count,
    input  wire issue_pkg::decoded_inst_t o_issue1,
    input  wire issue_pkg::decoded_inst_t o_issue2
);

    int err_count = 0;  // failed assertion count

    // slot 2 is only ever filled behind slot 1
    slot2_needs_slot1: assert property (@(posedge clk) disable iff (!rstn)
        i_valid2 |-> i_valid1)
        else begin
            $error("slot 2 valid without slot 1");
            err_count++;
        end

    no_push_when_full: assert property (@(posedge clk) disable iff (!rstn)
        o_full |-> !i_valid1)  // upstream must hold off
        else begin
            $error("push while the full flag is high");
            err_count++;
        end

    no_issue_in_stall: assert property (@(posedge clk) disable iff (!rstn)
        (i_stall_mem || i_stall_ex) |-> (o_issue_count == 2'd0))
        else begin
            $error("issue during a stall cycle");
            err_count++;
        end

    slot_b_after_a: assert property (@(posedge clk) disable iff (!rstn)
        o_issue2.valid |-> o_issue1.valid)
        else begin
            $error("slot b issued without slot a");
            err_count++;
        end

endmodule

`default_nettype wire

// ==== testbench/issue_stage_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "issue_defs.svh"

module issue_stage_tb;

    localparam int N_ROWS  = 29;
    localparam int TIMEOUT = 2 * N_ROWS + 50;  // cycles

    typedef struct packed {
        logic [1:0]  valid;  // {slot 1, slot 2}
        logic [31:0] instr1;
        logic [31:0] instr2;
        logic [1:0]  stall;  // {mem, ex}
        logic        flush;
        logic [1:0]  exp_count;
        logic        exp_full;
    } row_t;

    logic                     clk;
    logic                     rstn;
    logic                     i_valid1;
    logic [31:0]              i_instr1;
    logic [31:0]              i_pc1;
    logic                     i_valid2;
    logic [31:0]              i_instr2;
    logic [31:0]              i_pc2;
    logic                     i_flush;
    logic                     i_stall_mem;
    logic                     i_stall_ex;
    logic [1:0]               o_issue_count;
    issue_pkg::decoded_inst_t o_issue1;
    issue_pkg::decoded_inst_t o_issue2;
    logic [4:0]               o_a_raddr1;
    logic [4:0]               o_a_raddr2;
    logic [4:0]               o_b_raddr1;
    logic [4:0]               o_b_raddr2;
    logic [13:0]              o_csr_raddr1;
    logic [13:0]              o_csr_raddr2;
    logic                     o_full;

    row_t                     rows [N_ROWS];
    int                       n_rows = 0;
    issue_pkg::decoded_inst_t model_q [$];  // expected buffer contents, oldest first
    integer                   seed;
    logic [31:0]              next_pc;
    int                       cycles = 0;

    issue_stage uut (.*);

    bind issue_stage issue_stage_checker u_checker (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(negedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("run did not finish within %0d cycles", TIMEOUT);
            stop_run();
        end else if (uut.u_checker.err_count != 0) begin
            $display("a checker assertion failed at %0t", $time);
            stop_run();
        end
    end

    task automatic stop_run();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // instruction encoding and expected predecode
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] encode(input logic [5:0] op, input int rd,
                                           input int rj, input int rk);
        encode = {op, 11'd0, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] alu_rr(input int rd, input int rj, input int rk);
        alu_rr = encode(`OPC_ALU_R, rd, rj, rk);
    endfunction

    function automatic logic [31:0] csr_xchg(input int rd, input int csr);
        csr_xchg = {`OPC_CSR, 2'd0, csr[13:0], 5'd0, rd[4:0]};
    endfunction

    function automatic issue_pkg::decoded_inst_t expect_decode(input logic [31:0] w,
                                                                input logic [31:0] pc);
        issue_pkg::decoded_inst_t d;
        logic [5:0]               op;
        op         = w[31:26];
        d          = '0;
        d.valid    = 1'b1;
        d.pc       = pc;
        d.instr    = w;
        d.rd       = w[4:0];
        d.imm      = w[21:10];
        d.kind     = (op inside {`OPC_ALU_R, `OPC_ALU_I}) ? issue_pkg::KIND_ALU :
                     (op == `OPC_LOAD)   ? issue_pkg::KIND_LOAD :
                     (op == `OPC_STORE)  ? issue_pkg::KIND_STORE :
                     (op == `OPC_BRANCH) ? issue_pkg::KIND_BRANCH :
                     (op == `OPC_CSR)    ? issue_pkg::KIND_CSR : issue_pkg::KIND_ILLEGAL;
        d.rf_raddr1 = (op == `OPC_CSR) ? w[4:0] :
                      (d.kind == issue_pkg::KIND_ILLEGAL) ? 5'd0 : w[9:5];
        d.uses_r2   = op inside {`OPC_ALU_R, `OPC_STORE, `OPC_BRANCH};
        d.rf_raddr2 = (op == `OPC_ALU_R) ? w[14:10] : (d.uses_r2 ? w[4:0] : 5'd0);
        d.rf_we     = (op inside {`OPC_ALU_R, `OPC_ALU_I, `OPC_LOAD, `OPC_CSR}) &&
                      (w[4:0] != 5'd0);  // r0 never written
        d.csr_addr  = (op == `OPC_CSR) ? w[23:10] : 14'd0;
        expect_decode = d;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_count(input logic [1:0] act, input logic [1:0] exp);
        if (act !== exp) begin
            $display("mismatch at %0t: o_issue_count expected %0d, got %0d", $time, exp, act);
            stop_run();
        end
    endtask

    task automatic check_full(input logic act, input logic exp);
        if (act !== exp) begin
            $display("mismatch at %0t: o_full expected %b, got %b", $time, exp, act);
            stop_run();
        end
    endtask

    task automatic check_inst(input string name, input issue_pkg::decoded_inst_t act,
                              input issue_pkg::decoded_inst_t exp);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input logic [4:0] act, input logic [4:0] exp);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_csr(input string name, input logic [13:0] act,
                             input logic [13:0] exp);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic compare_outputs(input logic [1:0] exp_count, input logic exp_full);
        issue_pkg::decoded_inst_t exp_b;
        exp_b = '0;  // idle slot b
        check_count(o_issue_count, exp_count);
        check_full(o_full, exp_full);
        if (exp_count != 2'd0) begin
            check_inst("o_issue1", o_issue1, model_q[0]);
            check_addr("o_a_raddr1", o_a_raddr1, model_q[0].rf_raddr1);
            check_addr("o_a_raddr2", o_a_raddr2, model_q[0].rf_raddr2);
            check_csr("o_csr_raddr1", o_csr_raddr1, model_q[0].csr_addr);
        end
        if (exp_count == 2'd2) begin
            exp_b = model_q[1];
        end
        check_inst("o_issue2", o_issue2, exp_b);
        check_addr("o_b_raddr1", o_b_raddr1, exp_b.rf_raddr1);
        check_addr("o_b_raddr2", o_b_raddr2, exp_b.rf_raddr2);
        check_csr("o_csr_raddr2", o_csr_raddr2, exp_b.csr_addr);
    endtask

    // pops first, then this cycle's pushes unless flushed
    task automatic advance_model(input row_t row);
        repeat (row.exp_count) begin
            void'(model_q.pop_front());
        end
        if (row.flush) begin
            model_q.delete();
        end else begin
            if (row.valid[1]) model_q.push_back(expect_decode(row.instr1, next_pc));
            if (row.valid[0]) model_q.push_back(expect_decode(row.instr2, next_pc + 32'd4));
        end
        next_pc = next_pc + 32'd8;
    endtask

    task automatic add_row(input logic [1:0] valid, input logic [31:0] w1,
                           input logic [31:0] w2, input logic [1:0] stall, input logic flush,
                           input logic [1:0] cnt, input logic full);
        rows[n_rows] = '{valid, w1, w2, stall, flush, cnt, full};
        n_rows++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus table and main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed        = 99043;
        next_pc     = 32'($random(seed)) & 32'hffff_fff0;
        rstn        = 1'b0;
        i_valid1    = 1'b0;
        i_instr1    = '0;
        i_pc1       = '0;
        i_valid2    = 1'b0;
        i_instr2    = '0;
        i_pc2       = '0;
        i_flush     = 1'b0;
        i_stall_mem = 1'b0;
        i_stall_ex  = 1'b0;

        // in-order pairs, raw, r0, load/store, csr, branch, illegal
        add_row(2'b11, alu_rr(1, 2, 3), alu_rr(4, 5, 6), 2'b00, 1'b0, 2'd0, 1'b0);
        add_row(2'b11, alu_rr(7, 8, 9), alu_rr(10, 11, 12), 2'b00, 1'b0, 2'd2, 1'b0);
        add_row(2'b11, alu_rr(3, 1, 2), alu_rr(0, 3, 4), 2'b00, 1'b0, 2'd2, 1'b0);
        add_row(2'b10, alu_rr(6, 0, 0), 32'd0, 2'b00, 1'b0, 2'd1, 1'b0);
        add_row(2'b11, encode(`OPC_LOAD, 8, 1, 0), encode(`OPC_STORE, 9, 2, 0),
                2'b00, 1'b0, 2'd2, 1'b0);
        add_row(2'b11, csr_xchg(10, 'h123), encode(`OPC_ALU_I, 11, 12, 13),
                2'b00, 1'b0, 2'd1, 1'b0);
        add_row(2'b11, encode(`OPC_BRANCH, 2, 1, 0), alu_rr(14, 15, 16),
                2'b00, 1'b0, 2'd1, 1'b0);
        add_row(2'b00, 32'd0, 32'd0, 2'b00, 1'b0, 2'd1, 1'b0);
        add_row(2'b00, 32'd0, 32'd0, 2'b00, 1'b0, 2'd1, 1'b0);
        add_row(2'b11, encode(6'h3f, 17, 18, 19), alu_rr(20, 21, 22), 2'b00, 1'b0, 2'd1, 1'b0);
        add_row(2'b00, 32'd0, 32'd0, 2'b00, 1'b0, 2'd2, 1'b0);
        add_row(2'b00, 32'd0, 32'd0, 2'b00, 1'b0, 2'd1, 1'b0);
        add_row(2'b00, 32'd0, 32'd0, 2'b00, 1'b0, 2'd0, 1'b0);
        // stall with pushes, full flag, drain
        add_row(2'b11, alu_rr(1, 2, 3), alu_rr(4, 5, 6), 2'b10, 1'b0, 2'd0, 1'b0);
        add_row(2'b11, alu_rr(7, 8, 9), alu_rr(10, 11, 12), 2'b01, 1'b0, 2'd0, 1'b0);
        add_row(2'b11, alu_rr(13, 14, 15), alu_rr(16, 17, 18), 2'b11, 1'b0, 2'd0, 1'b0);
        add_row(2'b11, alu_rr(19, 20, 21), alu_rr(22, 23, 24), 2'b10, 1'b0, 2'd0, 1'b0);
        add_row(2'b00, 32'd0, 32'd0, 2'b10, 1'b0, 2'd0, 1'b0);
        add_row(2'b00, 32'd0, 32'd0, 2'b01, 1'b0, 2'd0, 1'b1);
        add_row(2'b00, 32'd0, 32'd0, 2'b00, 1'b0, 2'd2, 1'b1);
        add_row(2'b00, 32'd0, 32'd0, 2'b00, 1'b0, 2'd2, 1'b0);
        add_row(2'b00, 32'd0, 32'd0, 2'b00, 1'b0, 2'd2, 1'b0);
        add_row(2'b00, 32'd0, 32'd0, 2'b00, 1'b0, 2'd2, 1'b0);
        // flush drops resident and incoming entries
        add_row(2'b11, alu_rr(1, 2, 3), alu_rr(4, 5, 6), 2'b00, 1'b0, 2'd0, 1'b0);
        add_row(2'b11, alu_rr(7, 8, 9), alu_rr(10, 11, 12), 2'b10, 1'b0, 2'd0, 1'b0);
        add_row(2'b11, alu_rr(13, 14, 15), alu_rr(16, 17, 18), 2'b00, 1'b1, 2'd0, 1'b0);
        add_row(2'b11, alu_rr(20, 21, 22), alu_rr(23, 24, 25), 2'b00, 1'b0, 2'd0, 1'b0);
        add_row(2'b00, 32'd0, 32'd0, 2'b00, 1'b0, 2'd2, 1'b0);
        add_row(2'b00, 32'd0, 32'd0, 2'b00, 1'b0, 2'd0, 1'b0);

        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        for (int r = 0; r < N_ROWS; r++) begin
            @(posedge clk);
            i_valid1    <= rows[r].valid[1];
            i_valid2    <= rows[r].valid[0];
            i_instr1    <= rows[r].instr1;
            i_instr2    <= rows[r].instr2;
            i_pc1       <= next_pc;
            i_pc2       <= next_pc + 32'd4;
            i_stall_mem <= rows[r].stall[1];
            i_stall_ex  <= rows[r].stall[0];
            i_flush     <= rows[r].flush;
            @(negedge clk);  // outputs settled from head registers
            compare_outputs(rows[r].exp_count, rows[r].exp_full);
            advance_model(rows[r]);
        end
        @(negedge clk);  // let the checker see the last row
        if (uut.u_checker.err_count != 0) begin
            $display("a checker assertion failed during the run");
            stop_run();
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
